//--- bench/tb_arena_display.sv
`timescale 1ns/1ns
`default_nettype none

`include "display_macros.svh"

module tb_arena_display;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL; // 416800
	localparam int FRAMES_RUN   = 9; // frames scanned by all tests together
	localparam int SEL_BLANK    = 0; // pixels outside the active window
	localparam int SEL_CENTRE   = 1; // centre pixel of every tile
	localparam int SEL_BRICK    = 2; // centre plus two mortar pixels per tile
	localparam int SEL_ACTIVE   = 3; // every active pixel

	logic pixel_clk;
	logic rst;
	display_pkg::tile_idx_t   p1_row, p1_col, p2_row, p2_col;
	display_pkg::grid_map_t   arena, bomb_lo, bomb_hi;
	display_pkg::game_state_t game_over;
	logic hsync, vsync;
	display_pkg::red_t   red;
	display_pkg::green_t green;
	display_pkg::blue_t  blue;

	int h, v;               // output raster position
	logic prev_hs, prev_vs;
	logic frame_start;      // current sample is (0,0)
	logic [31:0] lcg_state;
	int errors, test_errors, tests_run, tests_failed;

	tb_clock #(.PERIOD_NS(10)) i_tb_clock (.pixel_clk_o(pixel_clk));

	bomb_arena_display i_bomb_arena_display (
		.pixel_clk(pixel_clk), .rst(rst),
		.player1_row_i(p1_row), .player1_col_i(p1_col),
		.player2_row_i(p2_row), .player2_col_i(p2_col),
		.arena_i(arena), .bomb_lo_i(bomb_lo), .bomb_hi_i(bomb_hi),
		.game_over_i(game_over),
		.hsync_o(hsync), .vsync_o(vsync),
		.red_o(red), .green_o(green), .blue_o(blue)
	);

	////////////////////
	// helpers
	////////////////////
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int expected_rgb(int ph, int pv);
		int row, col, xo, yo, idx;
		logic [1:0] lvl;
		if (ph < `H_ACT_START || ph >= `H_ACT_END || pv < `V_ACT_START || pv >= `V_ACT_END)
			return 0; // blanking
		if (game_over != 0)
			return 0;
		row = (pv - `V_ACT_START) / `TILE_H;
		col = (ph - `H_ACT_START) / `TILE_W;
		xo  = (ph - `H_ACT_START) % `TILE_W;
		yo  = (pv - `V_ACT_START) % `TILE_H;
		idx = row * `GRID_N + col;
		if (row == int'(p1_row) && col == int'(p1_col))
			return 8'b000_111_00;
		if (row == int'(p2_row) && col == int'(p2_col))
			return 8'b000_000_11;
		if (arena[idx])
		begin
			if ((xo inside {0, 13, 26, 39, 52}) || (yo inside {0, 9, 19, 29, 39}))
				return 0; // mortar line
			return 8'b110_010_00;
		end
		lvl = {bomb_hi[idx], bomb_lo[idx]};
		case (lvl)
			2'd1:    return 8'b101_001_11;
			2'd2:    return 8'b100_000_11;
			2'd3:    return 8'b111_000_00;
			default: return 8'hff; // floor
		endcase
	endfunction

	function automatic logic pixel_selected(int mode, int ph, int pv);
		logic act;
		int xo, yo;
		act = ph >= `H_ACT_START && ph < `H_ACT_END && pv >= `V_ACT_START && pv < `V_ACT_END;
		if (mode == SEL_BLANK)
			return !act;
		if (!act || mode == SEL_ACTIVE)
			return act;
		xo = (ph - `H_ACT_START) % `TILE_W;
		yo = (pv - `V_ACT_START) % `TILE_H;
		if (xo == 32 && yo == 24)
			return 1'b1;
		return (mode == SEL_BRICK) && ((xo == 13 && yo == 5) || (xo == 40 && yo == 9));
	endfunction

	task automatic check_value(string name, int exp, int act);
		if (exp !== act)
		begin
			errors++;
			test_errors++;
			$display("FAILED %s: expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic report_test(string name);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %s: %s (%0d mismatches)", name, test_errors ? "failed" : "ok", test_errors);
		test_errors = 0;
	endtask

	// advance one pixel and track (h,v) from the output syncs only
	task automatic step_pixel();
		logic hs_fall, vs_fall;
		@(negedge pixel_clk);
		hs_fall = prev_hs && !hsync;
		vs_fall = prev_vs && !vsync;
		frame_start = hs_fall && vs_fall;
		if (hs_fall)
		begin
			h = 0;
			v = vs_fall ? 0 : v + 1;
		end
		else
			h++;
		prev_hs = hsync;
		prev_vs = vsync;
	endtask

	// entered at (0,0) and left at (0,0) of the next frame
	task automatic scan_frame(string name, int mode);
		for (int n = 0; n < FRAME_CYCLES; n++)
		begin
			if (pixel_selected(mode, h, v))
				check_value(name, expected_rgb(h, v), int'({red, green, blue}));
			step_pixel();
		end
	endtask

	task automatic randomize_maps();
		logic [31:0] r;
		for (int i = 0; i < `CELLS; i++)
		begin
			r = lcg_next();
			arena[i] = r[16] & r[17]; // about one tile in four is a block
			bomb_lo[i] = r[20];
			bomb_hi[i] = r[24];
		end
	endtask

	////////////////////
	// tests
	////////////////////
	task automatic reset_test();
		repeat (8)
		begin
			@(negedge pixel_clk);
			check_value("reset", 32'h300, int'({hsync, vsync, red, green, blue}));
		end
		rst = 1'b0;
		@(negedge pixel_clk);
		check_value("reset", 32'h3, int'({hsync, vsync}));
		check_value("reset", 0, int'({red, green, blue}));
		prev_hs = hsync;
		prev_vs = vsync;
		report_test("reset");
	endtask

	task automatic sync_timing_test();
		int hs_low, vs_low, line_low, bad_lines, lines;
		hs_low = 0;
		vs_low = 0;
		line_low = 0;
		bad_lines = 0;
		lines = 0;
		for (int n = 0; n < FRAME_CYCLES; n++)
		begin
			if (h == 0)
			begin
				lines++;
				line_low = 0;
			end
			if (!hsync)
			begin
				hs_low++;
				line_low++;
			end
			if (!vsync)
				vs_low++;
			if (h == `H_TOTAL - 1 && line_low != `H_PULSE)
				bad_lines++;
			step_pixel();
		end
		check_value("sync_timing", `V_TOTAL, lines);
		check_value("sync_timing", `V_TOTAL * `H_PULSE, hs_low);
		check_value("sync_timing", `V_PULSE * `H_TOTAL, vs_low); // 1600 cycles
		check_value("sync_timing", 0, bad_lines);
		report_test("sync_timing");
	endtask

	task automatic blanking_test();
		scan_frame("blanking", SEL_BLANK);
		report_test("blanking");
	endtask

	task automatic tile_colour_test();
		randomize_maps();
		scan_frame("tile_colours", SEL_CENTRE); // players parked off grid
		report_test("tile_colours");
	endtask

	task automatic mortar_player_test();
		arena = '1; // every tile a block
		p1_row = 4'd1;
		p1_col = 4'd1;
		p2_row = 4'd4;
		p2_col = 4'd7;
		scan_frame("mortar_players", SEL_BRICK);
		// shared tile where player 1 must win
		p2_row = 4'd1;
		p2_col = 4'd1;
		scan_frame("mortar_players", SEL_BRICK);
		report_test("mortar_players");
	endtask

	task automatic game_over_test();
		randomize_maps();
		for (int g = 1; g < 4; g++)
		begin
			game_over = display_pkg::game_state_t'(g);
			scan_frame("game_over", SEL_ACTIVE);
		end
		game_over = '0;
		scan_frame("game_over", SEL_CENTRE); // colours come back
		report_test("game_over");
	endtask

	initial
	begin
		rst = 1'b1;
		p1_row = 4'd15;
		p1_col = 4'd15;
		p2_row = 4'd15;
		p2_col = 4'd15;
		arena = '0;
		bomb_lo = '0;
		bomb_hi = '0;
		game_over = '0;
		h = 0;
		v = 0;
		prev_hs = 1'b1;
		prev_vs = 1'b1;
		frame_start = 1'b0;
		lcg_state = 32'd98466;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;

		reset_test();
		do
			step_pixel();
		while (!frame_start);

		sync_timing_test();
		blanking_test();
		tile_colour_test();
		mortar_player_test();
		game_over_test();

		$display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// watchdog covers all frames plus some margin
	initial
	begin
		repeat ((FRAMES_RUN + 3) * FRAME_CYCLES) @(posedge pixel_clk);
		$display("watchdog: the tests did not finish in time, no frame sync seen or a hang");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 10 // 100 MHz in sim time, the value is not critical
) (
	output logic pixel_clk_o
);

	initial
	begin
		pixel_clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) pixel_clk_o = ~pixel_clk_o; // half period high, half low
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hdl
hdl/display_pkg.sv
hdl/display_ifs.sv
hdl/vga_timing.sv
hdl/tile_locator.sv
hdl/cell_decoder.sv
hdl/pixel_shader.sv
hdl/bomb_arena_display.sv
bench/tb_clock.sv
bench/tb_arena_display.sv

//--- hdl/bomb_arena_display.sv
`timescale 1ns/1ns
`default_nettype none

module bomb_arena_display (
	input  wire                        pixel_clk,
	input  wire                        rst,
	// player positions in tiles
	input  display_pkg::tile_idx_t     player1_row_i,
	input  display_pkg::tile_idx_t     player1_col_i,
	input  display_pkg::tile_idx_t     player2_row_i,
	input  display_pkg::tile_idx_t     player2_col_i,
	// arena state, one bit per tile
	input  display_pkg::grid_map_t     arena_i,
	input  display_pkg::grid_map_t     bomb_lo_i,
	input  display_pkg::grid_map_t     bomb_hi_i,
	input  display_pkg::game_state_t   game_over_i,
	// vga out
	output logic                       hsync_o,
	output logic                       vsync_o,
	output display_pkg::red_t          red_o,
	output display_pkg::green_t        green_o,
	output display_pkg::blue_t         blue_o
);

	scan_if i_scan (); // timing to locator
	tile_if i_tile (); // locator to decoder
	cell_if i_cell (); // decoder to shader

	////////////////////
	// pipeline
	////////////////////
	vga_timing i_vga_timing (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.scan_o    (i_scan)
	);

	tile_locator i_tile_locator (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.scan_i    (i_scan),
		.tile_o    (i_tile)
	);

	cell_decoder i_cell_decoder (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.tile_i        (i_tile),
		.cell_o        (i_cell),
		.player1_row_i (player1_row_i),
		.player1_col_i (player1_col_i),
		.player2_row_i (player2_row_i),
		.player2_col_i (player2_col_i),
		.arena_i       (arena_i),
		.bomb_lo_i     (bomb_lo_i),
		.bomb_hi_i     (bomb_hi_i)
	);

	pixel_shader i_pixel_shader (
		.pixel_clk   (pixel_clk),
		.rst         (rst),
		.cell_i      (i_cell),
		.game_over_i (game_over_i),
		.hsync_o     (hsync_o),
		.vsync_o     (vsync_o),
		.red_o       (red_o),
		.green_o     (green_o),
		.blue_o      (blue_o)
	);

endmodule

`default_nettype wire

//--- hdl/cell_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "display_macros.svh"

module cell_decoder (
	input  wire                        pixel_clk,
	input  wire                        rst,
	tile_if.snk                        tile_i,
	cell_if.src                        cell_o,
	input  display_pkg::tile_idx_t     player1_row_i,
	input  display_pkg::tile_idx_t     player1_col_i,
	input  display_pkg::tile_idx_t     player2_row_i,
	input  display_pkg::tile_idx_t     player2_col_i,
	input  display_pkg::grid_map_t     arena_i,   // 1 = solid block
	input  display_pkg::grid_map_t     bomb_lo_i, // bomb level bit 0
	input  display_pkg::grid_map_t     bomb_hi_i  // bomb level bit 1
);

	localparam int IDX_W = $clog2(`CELLS); // 7 bits for 0..99

	logic [IDX_W-1:0] cell_idx; // row*10+col
	display_pkg::bomb_lvl_t bomb_lvl;
	logic p1_hit;
	logic p2_hit;
	logic block_hit;
	display_pkg::cell_kind_t kind_nxt;

	////////////////////
	// lookup and priority
	////////////////////
	always_comb
	begin
		cell_idx  = IDX_W'(tile_i.row) * IDX_W'(`GRID_N) + IDX_W'(tile_i.col);
		block_hit = arena_i[cell_idx];
		bomb_lvl  = {bomb_hi_i[cell_idx], bomb_lo_i[cell_idx]};
		// both coordinates must match
		p1_hit = (tile_i.row == player1_row_i) && (tile_i.col == player1_col_i);
		p2_hit = (tile_i.row == player2_row_i) && (tile_i.col == player2_col_i);

		if (p1_hit)
			kind_nxt = display_pkg::CELL_PLAYER1; // player 1 wins a shared tile
		else if (p2_hit)
			kind_nxt = display_pkg::CELL_PLAYER2;
		else if (block_hit)
			kind_nxt = display_pkg::CELL_BLOCK; // block hides any bomb under it
		else
		begin
			case (bomb_lvl)
				2'd1:    kind_nxt = display_pkg::CELL_BOMB1;
				2'd2:    kind_nxt = display_pkg::CELL_BOMB2;
				2'd3:    kind_nxt = display_pkg::CELL_BOMB3;
				default: kind_nxt = display_pkg::CELL_EMPTY; // plain floor
			endcase
		end
	end

	// control flags
	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			cell_o.hsync <= 1'b1;
			cell_o.vsync <= 1'b1;
			cell_o.de    <= 1'b0;
		end
		else
		begin
			cell_o.hsync <= tile_i.hsync;
			cell_o.vsync <= tile_i.vsync;
			cell_o.de    <= tile_i.de;
		end
	end

	// payload
	always_ff @(posedge pixel_clk)
	begin
		cell_o.kind  <= kind_nxt;
		cell_o.x_off <= tile_i.x_off;
		cell_o.y_off <= tile_i.y_off;
	end

endmodule

`default_nettype wire

//--- hdl/display_ifs.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////
// raster flags out of the timing generator
////////////////////
interface scan_if;
	logic hsync;       // active low
	logic vsync;       // active low
	logic de;          // inside the 640x480 window
	logic line_first;  // first active pixel of an active line
	logic frame_first; // first active pixel of active line 0

	modport src (output hsync, vsync, de, line_first, frame_first);
	modport snk (input hsync, vsync, de, line_first, frame_first);
endinterface

////////////////////
// tile position of the current pixel
////////////////////
interface tile_if;
	logic hsync;
	logic vsync;
	logic de;
	display_pkg::tile_idx_t row; // tile row, 0 at top
	display_pkg::tile_idx_t col; // tile column, 0 at left
	display_pkg::tile_off_t x_off; // pixel inside the tile
	display_pkg::tile_off_t y_off; // line inside the tile

	modport src (output hsync, vsync, de, row, col, x_off, y_off);
	modport snk (input hsync, vsync, de, row, col, x_off, y_off);
endinterface

////////////////////
// resolved cell kind for the shader
////////////////////
interface cell_if;
	logic hsync;
	logic vsync;
	logic de;
	display_pkg::cell_kind_t kind;
	// offsets still needed for the brick pattern
	display_pkg::tile_off_t x_off;
	display_pkg::tile_off_t y_off;

	modport src (output hsync, vsync, de, kind, x_off, y_off);
	modport snk (input hsync, vsync, de, kind, x_off, y_off);
endinterface

`default_nettype wire

//--- hdl/display_macros.svh
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

////////////////////
// raster timing, 640x480 at 25 MHz pixel clock
////////////////////
`define H_TOTAL      800 // pixels per line incl. blanking
`define V_TOTAL      521 // lines per frame incl. blanking
`define H_PULSE      96  // hsync low width in pixels
`define V_PULSE      2   // vsync low width in lines
`define H_ACT_START  144 // end of horizontal back porch
`define H_ACT_END    784 // start of horizontal front porch
`define V_ACT_START  31  // end of vertical back porch
`define V_ACT_END    511 // start of vertical front porch

////////////////////
// arena grid
////////////////////
`define TILE_W       64  // tile width in pixels
`define TILE_H       48  // tile height in lines
`define GRID_N       10  // tiles per side
`define CELLS        100 // GRID_N * GRID_N

// vector widths
`define COORD_W      10
`define TILE_IDX_W   4
`define TILE_OFF_W   6
`define BOMB_LVL_W   2
`define GAME_STATE_W 2
`define RED_W        3
`define GREEN_W      3
`define BLUE_W       2

`endif

//--- hdl/display_pkg.sv
`default_nettype none

`include "display_macros.svh"

package display_pkg;

	// raster counter value
	typedef logic [`COORD_W-1:0]      coord_t;
	// tile row or column, 0..9 on screen
	typedef logic [`TILE_IDX_W-1:0]   tile_idx_t;
	typedef logic [`TILE_OFF_W-1:0]   tile_off_t; // offset inside a tile
	// one bit per tile, index row*10+col
	typedef logic [`CELLS-1:0]        grid_map_t;
	typedef logic [`BOMB_LVL_W-1:0]   bomb_lvl_t; // 0 means no bomb
	typedef logic [`GAME_STATE_W-1:0] game_state_t; // non-zero blanks the arena

	// 3/3/2 colour channels
	typedef logic [`RED_W-1:0]   red_t;
	typedef logic [`GREEN_W-1:0] green_t;
	typedef logic [`BLUE_W-1:0]  blue_t;

	// what a tile shows, after priority resolution
	typedef enum logic [2:0] {
		CELL_EMPTY,
		CELL_BLOCK,
		CELL_BOMB1,
		CELL_BOMB2,
		CELL_BOMB3,
		CELL_PLAYER1,
		CELL_PLAYER2
	} cell_kind_t;

endpackage

`default_nettype wire

//--- hdl/pixel_shader.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_shader (
	input  wire                        pixel_clk,
	input  wire                        rst,
	cell_if.snk                        cell_i,
	input  display_pkg::game_state_t   game_over_i, // non-zero = game ended
	output logic                       hsync_o,
	output logic                       vsync_o,
	output display_pkg::red_t          red_o,
	output display_pkg::green_t        green_o,
	output display_pkg::blue_t         blue_o
);

	display_pkg::red_t   red_nxt;
	display_pkg::green_t green_nxt;
	display_pkg::blue_t  blue_nxt;
	logic mortar; // black line between bricks

	////////////////////
	// colour lookup
	////////////////////
	always_comb
	begin
		// vertical joints at x, horizontal courses at y
		mortar = (cell_i.x_off inside {6'd0, 6'd13, 6'd26, 6'd39, 6'd52}) ||
			(cell_i.y_off inside {6'd0, 6'd9, 6'd19, 6'd29, 6'd39});
		{red_nxt, green_nxt, blue_nxt} = '0; // black by default

		if (cell_i.de && (game_over_i == '0))
		begin
			case (cell_i.kind)
				display_pkg::CELL_EMPTY:
					{red_nxt, green_nxt, blue_nxt} = {3'b111, 3'b111, 2'b11}; // white floor
				display_pkg::CELL_BLOCK:
					if (!mortar)
						{red_nxt, green_nxt, blue_nxt} = {3'b110, 3'b010, 2'b00}; // brick
				display_pkg::CELL_BOMB1:
					{red_nxt, green_nxt, blue_nxt} = {3'b101, 3'b001, 2'b11};
				display_pkg::CELL_BOMB2:
					{red_nxt, green_nxt, blue_nxt} = {3'b100, 3'b000, 2'b11};
				display_pkg::CELL_BOMB3:
					{red_nxt, green_nxt, blue_nxt} = {3'b111, 3'b000, 2'b00}; // about to blow
				display_pkg::CELL_PLAYER1:
					{red_nxt, green_nxt, blue_nxt} = {3'b000, 3'b111, 2'b00}; // green
				display_pkg::CELL_PLAYER2:
					{red_nxt, green_nxt, blue_nxt} = {3'b000, 3'b000, 2'b11}; // blue
				default:
					{red_nxt, green_nxt, blue_nxt} = '0;
			endcase
		end
	end

	////////////////////
	// output register
	////////////////////
	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
		end
		else
		begin
			hsync_o <= cell_i.hsync; // stays aligned with colour
			vsync_o <= cell_i.vsync;
			red_o   <= red_nxt;
			green_o <= green_nxt;
			blue_o  <= blue_nxt;
		end
	end

endmodule

`default_nettype wire

//--- hdl/tile_locator.sv
`timescale 1ns/1ns
`default_nettype none

`include "display_macros.svh"

module tile_locator (
	input  wire    pixel_clk,
	input  wire    rst,
	scan_if.snk    scan_i,
	tile_if.src    tile_o
);

	display_pkg::tile_idx_t row_q; // current tile row
	display_pkg::tile_idx_t col_q; // current tile column
	display_pkg::tile_off_t x_off_q;
	display_pkg::tile_off_t y_off_q;
	logic x_last; // last pixel column of a tile
	logic y_last; // last line of a tile

	assign x_last = (x_off_q == display_pkg::tile_off_t'(`TILE_W - 1));
	assign y_last = (y_off_q == display_pkg::tile_off_t'(`TILE_H - 1));

	////////////////////
	// horizontal tracking
	////////////////////
	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			x_off_q <= '0;
			col_q   <= '0;
		end
		else if (scan_i.line_first)
		begin
			x_off_q <= '0; // restart at left edge
			col_q   <= '0;
		end
		else if (scan_i.de)
		begin
			if (x_last)
			begin
				x_off_q <= '0;
				col_q   <= col_q + 1'b1; // next tile to the right
			end
			else
				x_off_q <= x_off_q + 1'b1;
		end
	end

	////////////////////
	// vertical tracking, once per active line
	////////////////////
	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			y_off_q <= '0;
			row_q   <= '0;
		end
		else if (scan_i.frame_first)
		begin
			y_off_q <= '0; // top of the arena
			row_q   <= '0;
		end
		else if (scan_i.line_first)
		begin
			if (y_last)
			begin
				y_off_q <= '0;
				row_q   <= row_q + 1'b1; // next tile row down
			end
			else
				y_off_q <= y_off_q + 1'b1;
		end
	end

	// syncs ride along one register
	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			tile_o.hsync <= 1'b1;
			tile_o.vsync <= 1'b1;
			tile_o.de    <= 1'b0;
		end
		else
		begin
			tile_o.hsync <= scan_i.hsync;
			tile_o.vsync <= scan_i.vsync;
			tile_o.de    <= scan_i.de;
		end
	end

	assign tile_o.row   = row_q;
	assign tile_o.col   = col_q;
	assign tile_o.x_off = x_off_q;
	assign tile_o.y_off = y_off_q;

endmodule

`default_nettype wire

//--- hdl/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "display_macros.svh"

module vga_timing (
	input  wire    pixel_clk, // 25 MHz pixel clock
	input  wire    rst,       // async, active high
	scan_if.src    scan_o
);

	display_pkg::coord_t h_cnt; // 0..799
	display_pkg::coord_t v_cnt; // 0..520
	display_pkg::coord_t h_nxt;
	display_pkg::coord_t v_nxt;
	logic h_wrap;
	logic h_act_nxt;
	logic v_act_nxt;

	////////////////////
	// next counter values
	////////////////////
	// flags are registered from the next count
	// so they line up with the counter itself
	always_comb
	begin
		h_wrap = (h_cnt == display_pkg::coord_t'(`H_TOTAL - 1));
		h_nxt  = h_wrap ? '0 : h_cnt + 1'b1;
		if (!h_wrap)
			v_nxt = v_cnt; // hold within a line
		else if (v_cnt == display_pkg::coord_t'(`V_TOTAL - 1))
			v_nxt = '0; // end of frame
		else
			v_nxt = v_cnt + 1'b1;
		h_act_nxt = (h_nxt >= display_pkg::coord_t'(`H_ACT_START)) &&
			(h_nxt < display_pkg::coord_t'(`H_ACT_END));
		v_act_nxt = (v_nxt >= display_pkg::coord_t'(`V_ACT_START)) &&
			(v_nxt < display_pkg::coord_t'(`V_ACT_END));
	end

	////////////////////
	// counters and registered flags
	////////////////////
	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			// park at the last pixel so the first count after release is (0,0)
			h_cnt              <= display_pkg::coord_t'(`H_TOTAL - 1);
			v_cnt              <= display_pkg::coord_t'(`V_TOTAL - 1);
			scan_o.hsync       <= 1'b1; // syncs idle high
			scan_o.vsync       <= 1'b1;
			scan_o.de          <= 1'b0;
			scan_o.line_first  <= 1'b0;
			scan_o.frame_first <= 1'b0;
		end
		else
		begin
			h_cnt        <= h_nxt;
			v_cnt        <= v_nxt;
			scan_o.hsync <= (h_nxt >= display_pkg::coord_t'(`H_PULSE)); // low in pulse
			scan_o.vsync <= (v_nxt >= display_pkg::coord_t'(`V_PULSE));
			scan_o.de    <= h_act_nxt && v_act_nxt;
			// first pixel of an active line
			scan_o.line_first  <= v_act_nxt &&
				(h_nxt == display_pkg::coord_t'(`H_ACT_START));
			scan_o.frame_first <= (v_nxt == display_pkg::coord_t'(`V_ACT_START)) &&
				(h_nxt == display_pkg::coord_t'(`H_ACT_START)); // top left corner
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the arena display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_arena_display \
	--Mdir obj_dir -o sim_arena
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_arena > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -F -q "*** TEST FAILED ***" sim.log; then
	exit 1
fi
if ! grep -F -q "*** TEST PASSED ***" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0
